// File: compile.f
logic/adder_pkg.sv
logic/prefix_pg_gen.sv
logic/sparse_prefix_adder.sv
logic/operand_stage.sv
logic/result_stage.sv
logic/adder_top.sv
sim/tb_clock.sv
sim/adder_assert.sv
sim/adder_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = adder_tb
FILELIST  = compile.f
SIM       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: sim/adder_tb.sv
`timescale 1ns/1ps
`default_nettype none
// testbench for the 64-bit add/subtract/compare unit
// directed carry, overflow and compare cases, then random streams with a
// reference model and an in-order expected queue

module adder_tb import adder_pkg::*; ();

   typedef struct packed {
      logic [data_width-1:0] result;
      logic                  carry;
      logic                  overflow;
      logic                  zero;
      logic                  negative;
   } expect_t;

   logic                  clk;
   logic                  reset;
   logic                  in_valid;
   alu_op_t               op;
   logic [data_width-1:0] a;
   logic [data_width-1:0] b;
   logic                  carry_in;
   logic                  out_valid;
   logic [data_width-1:0] result;
   logic                  carry;
   logic                  overflow;
   logic                  zero;
   logic                  negative;

   expect_t     exp_q[$];
   string       name_q[$];
   string       test_name;
   int          issued;
   int          checked;
   logic [31:0] lcg_state;

   tb_clock #(.period_ns(4.0)) u_clock (.clk(clk));

   adder_top dut (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .op        (op),
      .a         (a),
      .b         (b),
      .carry_in  (carry_in),
      .out_valid (out_valid),
      .result    (result),
      .carry     (carry),
      .overflow  (overflow),
      .zero      (zero),
      .negative  (negative)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [data_width-1:0] random_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcg_next();
      lo = lcg_next();
      return {hi, lo};
   endfunction

   function automatic alu_op_t random_op();
      logic [31:0] r;
      r = lcg_next() >> 16;
      case (r % 5)
         0: return op_add;
         1: return op_addc;
         2: return op_sub;
         3: return op_sltu;
         default: return op_slt;
      endcase
   endfunction

   // reference model from plain wide arithmetic
   function automatic expect_t expected_response(input alu_op_t o,
         input logic [data_width-1:0] x, input logic [data_width-1:0] y,
         input logic ci);
      expect_t                      e;
      logic [data_width:0]          wide;
      logic [data_width-1:0]        s;
      logic                         c;
      logic signed [data_width+1:0] exact;  // signed result before wrapping
      if (o == op_add || o == op_addc) begin
         wide = {1'b0, x} + {1'b0, y} + ((o == op_addc) ? {64'd0, ci} : 65'd0);
         s = wide[data_width-1:0];
         c = wide[data_width];
         exact = 66'($signed(x)) + 66'($signed(y)) + 66'((o == op_addc) & ci);
      end else begin
         s = x - y;
         c = (x >= y);  // no borrow
         exact = 66'($signed(x)) - 66'($signed(y));
      end
      e.result = s;
      if (o == op_sltu) e.result = {63'd0, x < y};
      if (o == op_slt) e.result = {63'd0, $signed(x) < $signed(y)};
      e.carry = c;
      e.overflow = (exact != 66'($signed(s)));  // signed result does not fit
      e.zero = (s == 64'd0);
      e.negative = s[63];
      return e;
   endfunction

   task automatic check_value(input string name, input logic [data_width-1:0] expected,
         input logic [data_width-1:0] actual);
      if (expected !== actual) begin
         $display("FAILED %s: expected %0h actual %0h", name, expected, actual);
         $display("TESTS FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic send(input string name, input alu_op_t o, input logic [data_width-1:0] x,
         input logic [data_width-1:0] y, input logic ci);
      @(negedge clk);
      test_name = name;
      op = o;
      a = x;
      b = y;
      carry_in = ci;
      in_valid = 1'b1;
      issued++;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         in_valid = 1'b0;
      end
   endtask

   task automatic wait_drain(input int limit);
      int cycles;
      cycles = 0;
      while (checked != issued) begin
         @(posedge clk);
         cycles++;
         if (cycles > limit) begin
            $display("timeout: %0d of %0d responses arrived", checked, issued);
            $display("TESTS FAILED");
            $fatal(1, "response timeout");
         end
      end
   endtask

   // expected entry captured where the DUT samples the request
   always @(posedge clk) begin
      if (!reset && in_valid) begin
         exp_q.push_back(expected_response(op, a, b, carry_in));
         name_q.push_back(test_name);
      end
   end

   always @(negedge clk) begin
      expect_t e;
      string   tname;
      if (out_valid) begin
         if (exp_q.size() == 0) begin
            $display("out_valid seen with no request outstanding");
            $display("TESTS FAILED");
            $fatal(1, "unexpected response");
         end else begin
            e = exp_q.pop_front();
            tname = name_q.pop_front();
            check_value({tname, " result"}, e.result, result);
            check_value({tname, " carry"}, 64'(e.carry), 64'(carry));
            check_value({tname, " overflow"}, 64'(e.overflow), 64'(overflow));
            check_value({tname, " zero"}, 64'(e.zero), 64'(zero));
            check_value({tname, " negative"}, 64'(e.negative), 64'(negative));
            checked++;
         end
      end
   end

   initial begin
      logic [data_width-1:0] x;
      logic [data_width-1:0] ones;
      logic [31:0]           r;
      int                    gap;
      lcg_state = 32'd58270;
      issued = 0;
      checked = 0;
      test_name = "idle";
      reset = 1'b1;
      in_valid = 1'b0;
      op = op_add;
      a = '0;
      b = '0;
      carry_in = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      idle(6);  // quiet after reset

      ones = '1;
      send("add wrap", op_add, ones, 64'd1, 1'b0);
      send("addc wrap", op_addc, ones, 64'd0, 1'b1);
      for (int k = 0; k < 16; k++) begin
         x = ones >> (60 - 4 * k);  // low 4k+4 bits set
         send($sformatf("add ripple to bit %0d", 4 * k + 4), op_add, x, 64'd1, 1'b0);
         send($sformatf("addc ripple to bit %0d", 4 * k + 4), op_addc, x, 64'd0, 1'b1);
         send($sformatf("add nibble %0d", k), op_add, ones << (4 * k),
            64'd1 << (4 * k), 1'b0);
      end
      idle(1);

      send("sub min minus one", op_sub, 64'h8000_0000_0000_0000, 64'd1, 1'b0);
      send("sub min minus max", op_sub, 64'h8000_0000_0000_0000,
         64'h7fff_ffff_ffff_ffff, 1'b0);
      send("sub max minus neg one", op_sub, 64'h7fff_ffff_ffff_ffff, ones, 1'b0);
      send("sub equal", op_sub, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0, 1'b0);
      send("sub zero minus one", op_sub, 64'd0, 64'd1, 1'b0);
      idle(1);

      x = random_word();
      for (int k = 0; k < 2; k++) begin
         send("cmp equal", k == 0 ? op_sltu : op_slt, x, x, 1'b0);
         send("cmp below", k == 0 ? op_sltu : op_slt, x, x + 64'd1, 1'b0);
         send("cmp above", k == 0 ? op_sltu : op_slt, x + 64'd1, x, 1'b0);
         send("cmp neg vs pos", k == 0 ? op_sltu : op_slt, ones, 64'd1, 1'b0);
         send("cmp pos vs neg", k == 0 ? op_sltu : op_slt, 64'd1, ones, 1'b0);
         send("cmp min vs max", k == 0 ? op_sltu : op_slt, 64'h8000_0000_0000_0000,
            64'h7fff_ffff_ffff_ffff, 1'b0);
      end
      for (int k = 0; k < 20; k++) begin
         send("cmp random", k[0] ? op_slt : op_sltu, random_word(), random_word(), 1'b0);
      end
      idle(1);
      wait_drain(50);

      for (int k = 0; k < 300; k++) begin
         r = lcg_next();
         send("stream", random_op(), random_word(), random_word(), r[31]);
      end
      idle(1);
      wait_drain(50);

      for (int k = 0; k < 100; k++) begin
         r = lcg_next();
         send("gaps", random_op(), random_word(), random_word(), r[31]);
         gap = int'((lcg_next() >> 20) % 4);
         idle(gap);
      end
      idle(1);
      wait_drain(50);
      idle(4);  // catch stray strobes

      if (checked == issued && exp_q.size() == 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         $display("response count mismatch: %0d issued, %0d checked", issued, checked);
         $display("TESTS FAILED");
         $fatal(1, "response count mismatch");
      end
   end

endmodule

`default_nettype wire

// File: sim/adder_assert.sv
`timescale 1ns/1ps
`default_nettype none
// protocol checks on the request and response strobes of adder_top
// fixed two-edge latency, no strobe out of reset

module adder_assert (
   input logic clk,
   input logic reset,
   input logic in_valid,
   input logic out_valid
);

   // reset clears the response strobe on the next edge
   a_reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
      else $error("out_valid high during or right after reset");

   a_req_to_resp: assert property (@(posedge clk) disable iff (reset)
      in_valid |-> ##2 out_valid)
      else $error("request not answered two edges later");

   a_no_orphan: assert property (@(posedge clk) disable iff (reset)
      out_valid |-> $past(in_valid, 2))
      else $error("out_valid without a request two edges earlier");

endmodule

bind adder_top adder_assert u_adder_assert (
   .clk       (clk),
   .reset     (reset),
   .in_valid  (in_valid),
   .out_valid (out_valid)
);

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none
// free-running testbench clock

module tb_clock #(
   parameter real period_ns = 4.0
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(period_ns / 2.0) clk = ~clk;  // half period per phase

endmodule

`default_nettype wire

// File: logic/adder_top.sv
`timescale 1ns/1ps
`default_nettype none
// 64-bit add/subtract/compare unit
// two register stages around the sparse prefix adder, one request per cycle,
// fixed latency of two clock edges

module adder_top import adder_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  in_valid,
   input  alu_op_t               op,
   input  logic [data_width-1:0] a,
   input  logic [data_width-1:0] b,
   input  logic                  carry_in,
   output logic                  out_valid,
   output logic [data_width-1:0] result,
   output logic                  carry,
   output logic                  overflow,
   output logic                  zero,
   output logic                  negative
);

   logic                  stage_valid;
   alu_op_t               stage_op;
   logic [data_width-1:0] opa;
   logic [data_width-1:0] opb_cond;
   logic                  cin;
   logic [data_width-1:0] sum;
   logic                  cout;

   operand_stage u_operand_stage (
      .clk         (clk),
      .reset       (reset),
      .in_valid    (in_valid),
      .op          (op),
      .a           (a),
      .b           (b),
      .carry_in    (carry_in),
      .stage_valid (stage_valid),
      .stage_op    (stage_op),
      .opa         (opa),
      .opb_cond    (opb_cond),
      .cin         (cin)
   );

   sparse_prefix_adder u_adder (
      .opa      (opa),
      .opb_cond (opb_cond),
      .cin      (cin),
      .sum      (sum),
      .cout     (cout)
   );

   result_stage u_result_stage (
      .clk         (clk),
      .reset       (reset),
      .stage_valid (stage_valid),
      .stage_op    (stage_op),
      .opa_sign    (opa[data_width-1]),
      .opb_sign    (opb_cond[data_width-1]),  // sign after inversion
      .sum         (sum),
      .cout        (cout),
      .out_valid   (out_valid),
      .result      (result),
      .carry       (carry),
      .overflow    (overflow),
      .zero        (zero),
      .negative    (negative)
   );

endmodule

`default_nettype wire

// File: logic/result_stage.sv
`timescale 1ns/1ps
`default_nettype none
// result stage of the add/compare pipeline
// derives the flags from the adder output, picks the sum or the
// compare bit and registers the response

module result_stage import adder_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  stage_valid,
   input  alu_op_t               stage_op,
   input  logic                  opa_sign,
   input  logic                  opb_sign,
   input  logic [data_width-1:0] sum,
   input  logic                  cout,
   output logic                  out_valid,
   output logic [data_width-1:0] result,
   output logic                  carry,
   output logic                  overflow,
   output logic                  zero,
   output logic                  negative
);

   logic                  sum_sign;
   logic                  ovf;
   logic                  is_zero;
   logic [data_width-1:0] res_sel;

   assign sum_sign = sum[data_width-1];
   assign ovf      = (opa_sign == opb_sign) && (sum_sign != opa_sign);
   assign is_zero  = (sum == '0);

   always_comb begin
      case (stage_op)
         op_sltu: res_sel = {{(data_width-1){1'b0}}, ~cout};  // borrow means a < b
         op_slt:  res_sel = {{(data_width-1){1'b0}}, sum_sign ^ ovf};
         default: res_sel = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= stage_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (stage_valid) begin
         result   <= res_sel;
         carry    <= cout;
         overflow <= ovf;
         zero     <= is_zero;
         negative <= sum_sign;
      end
   end

endmodule

`default_nettype wire

// File: logic/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none
// operand stage of the add/compare pipeline
// registers each request and prepares the adder operands, so subtract
// and compare become a + ~b + 1

module operand_stage import adder_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  in_valid,
   input  alu_op_t               op,
   input  logic [data_width-1:0] a,
   input  logic [data_width-1:0] b,
   input  logic                  carry_in,
   output logic                  stage_valid,
   output alu_op_t               stage_op,
   output logic [data_width-1:0] opa,
   output logic [data_width-1:0] opb_cond,
   output logic                  cin
);

   logic                  sub_like;
   logic [data_width-1:0] b_cond;
   logic                  cin_sel;

   assign sub_like = (op == op_sub) || (op == op_sltu) || (op == op_slt);
   assign b_cond   = sub_like ? ~b : b;

   always_comb begin
      case (op)
         op_addc: cin_sel = carry_in;
         op_sub,
         op_sltu,
         op_slt:  cin_sel = 1'b1;  // two's complement +1
         default: cin_sel = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         stage_valid <= 1'b0;
      end else begin
         stage_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         stage_op <= op;
         opa      <= a;
         opb_cond <= b_cond;
         cin      <= cin_sel;
      end
   end

endmodule

`default_nettype wire

// File: logic/sparse_prefix_adder.sv
`timescale 1ns/1ps
`default_nettype none
// 64-bit sparse parallel-prefix adder
// radix-2 tree resolves the carry at every fourth bit only
// and the three carries in between are rebuilt locally per nibble

module sparse_prefix_adder import adder_pkg::*; (
   input  logic [data_width-1:0] opa,
   input  logic [data_width-1:0] opb_cond,
   input  logic                  cin,
   output logic [data_width-1:0] sum,
   output logic                  cout
);

   logic [data_width:0]   p;  // index 0 is the carry-in slot
   logic [data_width:0]   g;

   // groups reaching down to bit 0 carry no propagate, p[0] is zero
   logic [31:0]           gg_l1;
   logic [31:0]           gp_l1;
   logic [15:0]           gg_l2;
   logic [15:1]           gp_l2;
   logic [14:0]           gg_l3;
   logic [14:1]           gp_l3;
   logic [14:0]           gg_l4;
   logic [14:3]           gp_l4;
   logic [14:0]           gg_l5;
   logic [14:7]           gp_l5;
   logic [7:0]            gg_l6;

   logic [15:0]           sc;       // carries out of bits 3, 7 .. 63
   logic [15:0]           blk_cin;  // carry into each nibble
   logic [data_width-1:0] c;        // carry into each sum bit

   genvar i;

   prefix_pg_gen u_pg_gen (
      .opa      (opa),
      .opb_cond (opb_cond),
      .cin      (cin),
      .p        (p),
      .g        (g)
   );

   // pairs of bits
   for (i = 0; i < 32; i++) begin : g_l1
      assign gg_l1[i] = g[2*i+1] | p[2*i+1] & g[2*i];
      assign gp_l1[i] = p[2*i+1] & p[2*i];
   end

   // groups of four
   for (i = 0; i < 16; i++) begin : g_l2
      assign gg_l2[i] = gg_l1[2*i+1] | gp_l1[2*i+1] & gg_l1[2*i];
   end
   for (i = 1; i < 16; i++) begin : g_l2_p
      assign gp_l2[i] = gp_l1[2*i+1] & gp_l1[2*i];
   end

   // even entries hold octets, odd entries the nibble above each octet
   for (i = 0; i < 8; i++) begin : g_l3
      assign gg_l3[2*i] = gg_l2[2*i+1] | gp_l2[2*i+1] & gg_l2[2*i];
   end
   for (i = 1; i < 8; i++) begin : g_l3_p
      assign gp_l3[2*i] = gp_l2[2*i+1] & gp_l2[2*i];
   end
   for (i = 0; i < 7; i++) begin : g_l3_fwd
      assign gg_l3[2*i+1] = gg_l2[2*i+2];
      assign gp_l3[2*i+1] = gp_l2[2*i+2];
   end

   // spans of 12 and 16 bits
   assign gg_l4[0] = gg_l3[0];

   for (i = 0; i < 7; i++) begin : g_l4_odd
      assign gg_l4[2*i+1] = gg_l3[2*i+1] | gp_l3[2*i+1] & gg_l3[2*i];
   end
   for (i = 1; i < 7; i++) begin : g_l4_odd_p
      assign gp_l4[2*i+1] = gp_l3[2*i+1] & gp_l3[2*i];
   end
   for (i = 1; i < 8; i++) begin : g_l4_even
      assign gg_l4[2*i] = gg_l3[2*i] | gp_l3[2*i] & gg_l3[2*i-2];
   end
   for (i = 2; i < 8; i++) begin : g_l4_even_p
      assign gp_l4[2*i] = gp_l3[2*i] & gp_l3[2*i-2];
   end

   // entries 0 to 6 now reach bit 0
   assign gg_l5[2:0] = gg_l4[2:0];

   for (i = 1; i < 7; i++) begin : g_l5_odd
      assign gg_l5[2*i+1] = gg_l4[2*i+1] | gp_l4[2*i+1] & gg_l4[2*i-2];
   end
   for (i = 3; i < 7; i++) begin : g_l5_odd_p
      assign gp_l5[2*i+1] = gp_l4[2*i+1] & gp_l4[2*i-2];
   end
   for (i = 2; i < 8; i++) begin : g_l5_even
      assign gg_l5[2*i] = gg_l4[2*i] | gp_l4[2*i] & gg_l4[2*i-4];
   end
   for (i = 4; i < 8; i++) begin : g_l5_even_p
      assign gp_l5[2*i] = gp_l4[2*i] & gp_l4[2*i-4];
   end

   // upper half closes onto the lower prefixes
   for (i = 0; i < 4; i++) begin : g_l6
      assign gg_l6[2*i]   = gg_l5[2*i+7] | gp_l5[2*i+7] & gg_l5[2*i];
      assign gg_l6[2*i+1] = gg_l5[2*i+8] | gp_l5[2*i+8] & gg_l5[2*i];
   end

   assign sc[0]    = gg_l2[0];
   assign sc[7:1]  = gg_l5[6:0];
   assign sc[15:8] = gg_l6;

   assign blk_cin = {sc[14:0], 1'b0};

   // local fill of the three carries between sparse points
   for (i = 0; i < 16; i++) begin : g_fill
      assign c[4*i]   = g[4*i] | p[4*i] & blk_cin[i];
      assign c[4*i+1] = gg_l1[2*i] | gp_l1[2*i] & blk_cin[i];  // pair closes onto nibble carry
      assign c[4*i+2] = g[4*i+2] | p[4*i+2] & c[4*i+1];
      assign c[4*i+3] = sc[i];
   end

   assign sum  = p[data_width:1] ^ c;
   assign cout = g[data_width] | p[data_width] & sc[15];

endmodule

`default_nettype wire

// File: logic/prefix_pg_gen.sv
`timescale 1ns/1ps
`default_nettype none
// propagate and generate generator for the prefix adder
// bit 0 holds the carry-in as a plain generate so the tree needs no special case

module prefix_pg_gen import adder_pkg::*; (
   input  logic [data_width-1:0] opa,
   input  logic [data_width-1:0] opb_cond,
   input  logic                  cin,
   output logic [data_width:0]   p,
   output logic [data_width:0]   g
);

   assign g[0] = cin;
   assign p[0] = 1'b0;  // carry-in never propagates

   assign p[data_width:1] = opa ^ opb_cond;
   assign g[data_width:1] = opa & opb_cond;

endmodule

`default_nettype wire

// File: logic/adder_pkg.sv
`default_nettype none
// shared definitions of the 64-bit add/subtract/compare unit
// operand width and the opcode encoding used by every stage

package adder_pkg;

   // operand and result width, the prefix tree is wired for this value
   localparam int data_width = 64;

   typedef enum logic [2:0] {
      op_add  = 3'd0,  // a + b
      op_addc = 3'd1,  // a + b + carry_in
      op_sub  = 3'd2,  // a - b
      op_sltu = 3'd3,  // a < b unsigned
      op_slt  = 3'd4   // a < b signed
   } alu_op_t;

endpackage

`default_nettype wire
